// File: src/sensors_params.svh
// Address map, register offsets, field widths and reset defaults of the
// four-channel sensor subsystem. Include wherever a width or address is needed.
`ifndef SENSORS_PARAMS_SVH
`define SENSORS_PARAMS_SVH

`define SENS_NUM_CHN              4      // sensor channels behind one command port

`define CMD_ADDR_BITS             16     // assembled register address (AL, AH)
`define CMD_DATA_BITS             32     // assembled register data (D0..D3)

`define SENSOR_GROUP_ADDR         'h400  // channel 0 window base
`define SENSOR_BASE_INC           'h040  // window size and step per channel

`define SENSOR_CTRL_RADDR         'h00   // mode register
`define SENS_STATUS_CTRL_RADDR    'h01   // any write asks for one status packet
`define SENS_SYNC_MULT_RADDR      'h06   // frames combined into one, minus 1
`define SENS_SYNC_LATE_RADDR      'h07   // lines from sof to late sof

`define SENSOR_CHN_EN_BIT         0      // mode bit, channel enable

`define SENS_SYNC_FBITS           16     // multiplier and frame counter width
`define SENS_SYNC_LBITS           16     // line counter and late value width
`define SENS_SYNC_LATE_DFLT       15     // late value after reset

`define SENSI2C_STATUS_REG_BASE   'h20   // status address of channel 0
`define SENSI2C_STATUS_REG_INC    2      // status address step per channel

`define STATUS_BYTES              4      // address byte plus three payload bytes

`endif

// File: src/sensors_pkg.sv
// Shared types of the sensor subsystem: FSM states and the register select
// that the channel decoder hands to the sync block.
// Modules import it inside their body and use scoped names in their ports.
package sensors_pkg;

    // byte position inside a command, AL is taken from IDLE
    typedef enum logic [2:0] {
        IDLE,
        ADDR_HI,
        DATA0,
        DATA1,
        DATA2,
        DATA3
    } cmd_state_e;

    // decoded write target inside one channel window
    typedef enum logic [2:0] {
        REG_NONE,
        REG_MODE,
        REG_STATUS,
        REG_MULT,
        REG_LATE
    } reg_sel_e;

    typedef enum logic {
        SYNC_IDLE,
        SYNC_WAIT_LATE      // counting lines toward the late sof
    } sync_state_e;

    typedef enum logic [1:0] {
        ROUTE_IDLE,
        ROUTE_OFFER,        // status_rq up, waiting for status_start
        ROUTE_SEND          // remaining packet bytes
    } route_state_e;

endpackage

// File: src/cmd_deser.sv
// Byte-serial command deserializer. Registers cmd_ad/cmd_stb, then collects
// AL, AH, D0..D3 (lsb first) and issues a single-cycle register write that is
// broadcast to every channel. cmd_we comes 2 cycles after D3 is on the input.
`timescale 1ns/1ps
`include "sensors_params.svh"

module cmd_deser (
    input  logic                      mclk,
    input  logic                      reset,
    input  logic [7:0]                cmd_ad,     // AL, AH, D0..D3
    input  logic                      cmd_stb,    // high with AL
    output logic                      cmd_we,     // one-cycle write pulse
    output logic [`CMD_ADDR_BITS-1:0] cmd_addr,
    output logic [`CMD_DATA_BITS-1:0] cmd_data
);
    import sensors_pkg::*;

    logic [7:0] ad_r;       // input register
    logic       stb_r;
    cmd_state_e state;

    always_ff @(posedge mclk) begin
        ad_r <= cmd_ad;
        if (reset) begin
            stb_r <= 1'b0;
        end else begin
            stb_r <= cmd_stb;
        end
    end

    // control: strobe always restarts the sequence at AL
    always_ff @(posedge mclk) begin
        if (reset) begin
            state  <= IDLE;
            cmd_we <= 1'b0;
        end else begin
            cmd_we <= 1'b0;
            if (stb_r) begin
                state <= ADDR_HI;                // AL taken this cycle
            end else begin
                case (state)
                    ADDR_HI: state <= DATA0;
                    DATA0:   state <= DATA1;
                    DATA1:   state <= DATA2;
                    DATA2:   state <= DATA3;
                    DATA3: begin
                        state  <= IDLE;
                        cmd_we <= 1'b1;          // sixth byte in
                    end
                    default: state <= IDLE;      // idle, waiting for strobe
                endcase
            end
        end
    end

    // payload shifts in from the top, lsb byte ends at the bottom
    always_ff @(posedge mclk) begin
        if (stb_r) begin
            cmd_addr <= {ad_r, cmd_addr[`CMD_ADDR_BITS-1:8]};
        end else begin
            case (state)
                ADDR_HI: cmd_addr <= {ad_r, cmd_addr[`CMD_ADDR_BITS-1:8]};
                DATA0, DATA1, DATA2, DATA3:
                    cmd_data <= {ad_r, cmd_data[`CMD_DATA_BITS-1:8]};
                default: ;
            endcase
        end
    end

endmodule

// File: src/sens_sync.sv
// Frame sync of one sensor channel. Decimates sof_in by (mult+1), counts the
// frames that pass and produces a late start of frame after a programmed
// number of eol_in strobes. mult and late are written through reg_wr.
`timescale 1ns/1ps
`include "sensors_params.svh"

module sens_sync (
    input  logic                        mclk,
    input  logic                        reset,
    input  logic                        chn_en,
    input  sensors_pkg::reg_sel_e       reg_wr,        // REG_NONE when no write
    input  logic [`SENS_SYNC_FBITS-1:0] wr_data,
    input  logic                        sof_in,
    input  logic                        eol_in,
    output logic                        sof_out_mclk,
    output logic                        sof_late_mclk,
    output logic [`SENS_SYNC_FBITS-1:0] frame_count,   // passed frames
    output sensors_pkg::sync_state_e    sync_state
);
    import sensors_pkg::*;

    logic [`SENS_SYNC_FBITS-1:0] mult_r;      // frames to combine, minus 1
    logic [`SENS_SYNC_LBITS-1:0] late_r;      // lines to the late sof
    logic [`SENS_SYNC_FBITS-1:0] dec_cnt;     // position inside decimation group
    logic [`SENS_SYNC_LBITS-1:0] line_cnt;
    logic [`SENS_SYNC_LBITS:0]   lines_next;  // one extra bit, no wrap
    logic                        pass;

    assign pass       = chn_en && sof_in && (dec_cnt == '0);
    assign lines_next = {1'b0, line_cnt} + 1'b1;

    always_ff @(posedge mclk) begin
        if (reset) begin
            mult_r <= '0;
            late_r <= `SENS_SYNC_LBITS'(`SENS_SYNC_LATE_DFLT);
        end else if (reg_wr == REG_MULT) begin
            mult_r <= wr_data;
        end else if (reg_wr == REG_LATE) begin
            late_r <= wr_data[`SENS_SYNC_LBITS-1:0];
        end
    end

    // decimation and frame counter
    always_ff @(posedge mclk) begin
        if (reset) begin
            dec_cnt      <= '0;
            frame_count  <= '0;
            sof_out_mclk <= 1'b0;
        end else begin
            sof_out_mclk <= pass;                // 1 cycle after sof_in
            if (!chn_en) begin
                dec_cnt <= '0;                   // first sof after enable passes
            end else if (sof_in) begin
                dec_cnt <= (dec_cnt >= mult_r) ? '0 : dec_cnt + 1'b1;
            end
            if (pass) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // late sof, counted in lines from the passed sof
    always_ff @(posedge mclk) begin
        if (reset) begin
            sync_state    <= SYNC_IDLE;
            line_cnt      <= '0;
            sof_late_mclk <= 1'b0;
        end else begin
            sof_late_mclk <= 1'b0;
            if (pass) begin
                line_cnt <= '0;                  // new frame restarts the count
                if (late_r == '0) begin
                    sof_late_mclk <= 1'b1;       // same cycle as sof_out_mclk
                    sync_state    <= SYNC_IDLE;
                end else begin
                    sync_state    <= SYNC_WAIT_LATE;
                end
            end else if (!chn_en) begin
                sync_state <= SYNC_IDLE;         // disabled mid-frame
            end else if (sync_state == SYNC_WAIT_LATE && eol_in) begin
                if (lines_next >= {1'b0, late_r}) begin
                    sof_late_mclk <= 1'b1;
                    sync_state    <= SYNC_IDLE;
                end else begin
                    line_cnt <= lines_next[`SENS_SYNC_LBITS-1:0];
                end
            end
        end
    end

endmodule

// File: src/sensor_channel.sv
// One sensor channel. Decodes the broadcast register writes that fall into
// its own address window, keeps the mode register, runs the frame sync and
// answers status requests with a four-byte packet on the request/start bus.
// Instantiated once per channel with chn_num selecting window and status address.
`timescale 1ns/1ps
`include "sensors_params.svh"

module sensor_channel #(
    parameter int chn_num = 0                    // 0..3
) (
    input  logic                      mclk,
    input  logic                      reset,
    input  logic                      cmd_we,
    input  logic [`CMD_ADDR_BITS-1:0] cmd_addr,
    input  logic [`CMD_DATA_BITS-1:0] cmd_data,
    input  logic                      sof_in,
    input  logic                      eol_in,
    input  logic                      status_start,  // byte 0 taken this cycle
    output logic                      sof_out_mclk,
    output logic                      sof_late_mclk,
    output logic [7:0]                status_ad,
    output logic                      status_rq
);
    import sensors_pkg::*;

    localparam logic [`CMD_ADDR_BITS-1:0] chn_base =
        `CMD_ADDR_BITS'(`SENSOR_GROUP_ADDR + chn_num * `SENSOR_BASE_INC);
    localparam logic [7:0] stat_addr =
        8'(`SENSI2C_STATUS_REG_BASE + chn_num * `SENSI2C_STATUS_REG_INC);

    logic [`CMD_ADDR_BITS-1:0]   addr_off;       // wraps high below the window
    reg_sel_e                    reg_sel;
    logic                        chn_en;         // mode register
    logic                        status_wr;
    logic [`SENS_SYNC_FBITS-1:0] frame_count;
    sync_state_e                 sync_state;
    logic [8*`STATUS_BYTES-1:0]  pkt_sr;         // byte 0 at the bottom
    logic [8*`STATUS_BYTES-1:0]  snapshot;
    logic [1:0]                  send_cnt;       // bytes left after byte 0
    logic                        pend;           // request seen while sending

    assign addr_off = cmd_addr - chn_base;

    always_comb begin
        reg_sel = REG_NONE;
        if (cmd_we && (addr_off < `SENSOR_BASE_INC)) begin
            case (addr_off)
                `SENSOR_CTRL_RADDR:      reg_sel = REG_MODE;
                `SENS_STATUS_CTRL_RADDR: reg_sel = REG_STATUS;
                `SENS_SYNC_MULT_RADDR:   reg_sel = REG_MULT;
                `SENS_SYNC_LATE_RADDR:   reg_sel = REG_LATE;
                default:                 reg_sel = REG_NONE;
            endcase
        end
    end

    assign status_wr = (reg_sel == REG_STATUS);

    always_ff @(posedge mclk) begin
        if (reset) begin
            chn_en <= 1'b0;
        end else if (reg_sel == REG_MODE) begin
            chn_en <= cmd_data[`SENSOR_CHN_EN_BIT];
        end
    end

    sens_sync sens_sync_i (
        .mclk          (mclk),
        .reset         (reset),
        .chn_en        (chn_en),
        .reg_wr        (reg_sel),
        .wr_data       (cmd_data[`SENS_SYNC_FBITS-1:0]),
        .sof_in        (sof_in),
        .eol_in        (eol_in),
        .sof_out_mclk  (sof_out_mclk),
        .sof_late_mclk (sof_late_mclk),
        .frame_count   (frame_count),
        .sync_state    (sync_state)
    );

    // byte 3: {6'b0, waiting for late sof, enabled}
    assign snapshot = {6'b0, sync_state == SYNC_WAIT_LATE, chn_en,
                       frame_count[15:8], frame_count[7:0], stat_addr};

    always_ff @(posedge mclk) begin
        if (reset) begin
            status_rq <= 1'b0;
            send_cnt  <= '0;
            pend      <= 1'b0;
        end else if (status_rq && status_start) begin
            status_rq <= 1'b0;
            send_cnt  <= 2'(`STATUS_BYTES - 1);
            pend      <= status_wr;
        end else if (send_cnt != '0) begin
            send_cnt <= send_cnt - 1'b1;
            if (status_wr) begin
                pend <= 1'b1;                    // served after this packet
            end
        end else if (status_wr || pend) begin
            status_rq <= 1'b1;                   // repeated writes merge here
            pend      <= 1'b0;
        end
    end

    // packet snapshot, refreshed while still waiting for start
    always_ff @(posedge mclk) begin
        if ((status_rq && status_start) || send_cnt != '0) begin
            pkt_sr <= {8'h00, pkt_sr[8*`STATUS_BYTES-1:8]};
        end else if (status_wr || pend) begin
            pkt_sr <= snapshot;
        end
    end

    assign status_ad = pkt_sr[7:0];

endmodule

// File: src/status_router.sv
// Merges the per-channel status streams onto one request/start byte stream.
// Requests are served round-robin, starting after the channel served last;
// start is forwarded to the selected channel only and its bytes are muxed out.
`timescale 1ns/1ps
`include "sensors_params.svh"

module status_router (
    input  logic                       mclk,
    input  logic                       reset,
    input  logic [`SENS_NUM_CHN*8-1:0] chn_status_ad,
    input  logic [`SENS_NUM_CHN-1:0]   chn_status_rq,
    input  logic                       status_start,
    output logic [`SENS_NUM_CHN-1:0]   chn_status_start,
    output logic [7:0]                 status_ad,
    output logic                       status_rq
);
    import sensors_pkg::*;

    localparam int cw = $clog2(`SENS_NUM_CHN);

    route_state_e  state;
    logic [cw-1:0] sel;          // channel being offered or sent
    logic [cw-1:0] last;         // channel served last
    logic [cw-1:0] next_chn;
    logic          any_rq;
    logic [1:0]    byte_cnt;     // bytes left after byte 0

    // first requester after last, wrapping around
    always_comb begin
        int idx;
        next_chn = last;
        any_rq   = 1'b0;
        for (int k = `SENS_NUM_CHN; k >= 1; k--) begin
            idx = (int'(last) + k) % `SENS_NUM_CHN;
            if (chn_status_rq[idx]) begin
                next_chn = cw'(idx);         // nearest one wins, loop runs far to near
                any_rq   = 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (reset) begin
            state    <= ROUTE_IDLE;
            sel      <= '0;
            last     <= cw'(`SENS_NUM_CHN - 1);  // channel 0 goes first
            byte_cnt <= '0;
        end else begin
            case (state)
                ROUTE_IDLE: if (any_rq) begin
                    sel   <= next_chn;
                    state <= ROUTE_OFFER;
                end
                ROUTE_OFFER: if (status_start) begin
                    byte_cnt <= 2'(`STATUS_BYTES - 1);
                    state    <= ROUTE_SEND;
                end
                ROUTE_SEND: begin
                    byte_cnt <= byte_cnt - 1'b1;
                    if (byte_cnt == 2'd1) begin  // last byte out
                        last  <= sel;
                        state <= ROUTE_IDLE;
                    end
                end
                default: state <= ROUTE_IDLE;
            endcase
        end
    end

    assign status_rq = (state == ROUTE_OFFER);
    assign status_ad = chn_status_ad[sel*8 +: 8];

    always_comb begin
        chn_status_start = '0;
        if (state == ROUTE_OFFER && status_start) begin
            chn_status_start[sel] = 1'b1;
        end
    end

endmodule

// File: src/sensors_top.sv
// Sensor subsystem top: command deserializer, four identical channels and
// the status router, all on mclk. Only instances and interconnect live here.
`timescale 1ns/1ps
`include "sensors_params.svh"

module sensors_top (
    input  logic                     mclk,
    input  logic                     reset,
    input  logic [7:0]               cmd_ad,        // AL, AH, D0..D3
    input  logic                     cmd_stb,
    input  logic [`SENS_NUM_CHN-1:0] sof_in,        // already on mclk
    input  logic [`SENS_NUM_CHN-1:0] eol_in,
    input  logic                     status_start,
    output logic [`SENS_NUM_CHN-1:0] sof_out_mclk,
    output logic [`SENS_NUM_CHN-1:0] sof_late_mclk,
    output logic [7:0]               status_ad,
    output logic                     status_rq
);

    logic                       cmd_we;
    logic [`CMD_ADDR_BITS-1:0]  cmd_addr;
    logic [`CMD_DATA_BITS-1:0]  cmd_data;
    logic [`SENS_NUM_CHN*8-1:0] chn_status_ad;     // 8 bits per channel
    logic [`SENS_NUM_CHN-1:0]   chn_status_rq;
    logic [`SENS_NUM_CHN-1:0]   chn_status_start;

    cmd_deser cmd_deser_i (
        .mclk     (mclk),
        .reset    (reset),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .cmd_we   (cmd_we),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data)
    );

    for (genvar i = 0; i < `SENS_NUM_CHN; i++) begin : g_chn
        sensor_channel #(
            .chn_num (i)
        ) sensor_channel_i (
            .mclk          (mclk),
            .reset         (reset),
            .cmd_we        (cmd_we),               // broadcast write
            .cmd_addr      (cmd_addr),
            .cmd_data      (cmd_data),
            .sof_in        (sof_in[i]),
            .eol_in        (eol_in[i]),
            .status_start  (chn_status_start[i]),
            .sof_out_mclk  (sof_out_mclk[i]),
            .sof_late_mclk (sof_late_mclk[i]),
            .status_ad     (chn_status_ad[i*8 +: 8]),
            .status_rq     (chn_status_rq[i])
        );
    end

    status_router status_router_i (
        .mclk             (mclk),
        .reset            (reset),
        .chn_status_ad    (chn_status_ad),
        .chn_status_rq    (chn_status_rq),
        .status_start     (status_start),
        .chn_status_start (chn_status_start),
        .status_ad        (status_ad),
        .status_rq        (status_rq)
    );

endmodule

// File: tb/tb_sensors.sv
// Directed testbench of the sensor subsystem top. Each test task drives
// commands, frame and line strobes and status_start, then checks the DUT
// response against values worked out from the subsystem rules.
`timescale 1ns/1ps
`include "sensors_params.svh"

module tb_sensors;
    import sensors_pkg::*;

    localparam int max_cycles = 20000;  // tests need about 2000 cycles

    logic       mclk;
    logic       reset;
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic [3:0] sof_in;
    logic [3:0] eol_in;
    logic       status_start;
    logic [3:0] sof_out_mclk;
    logic [3:0] sof_late_mclk;
    logic [7:0] status_ad;
    logic       status_rq;

    int          frames [4] = '{0, 0, 0, 0};  // expected passed frames per channel
    sync_state_e exp_sync [4] = '{SYNC_IDLE, SYNC_IDLE, SYNC_IDLE, SYNC_IDLE};
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;
    string       cur_test = "reset";

    sensors_top UUT (.*);

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;        // 8 ns period
    end

    always @(posedge mclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("run stopped after %0d cycles, still in test %s", cycle_cnt, cur_test);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
                 cur_test, what, expected, actual);
        test_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("error in %s, %s", cur_test, msg);
        test_errors++;
    endtask

    task automatic end_test();
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, test_errors);
        end
        test_errors = 0;
    endtask

    // AL, AH, D0..D3, strobe high with AL
    task automatic write_reg(input logic [1:0] chn, input int off, input logic [31:0] data);
        logic [47:0] seq;
        seq = {data, 16'(`SENSOR_GROUP_ADDR + int'(chn) * `SENSOR_BASE_INC + off)};
        for (int i = 0; i < 6; i++) begin
            @(posedge mclk);
            cmd_ad  <= seq[7:0];
            cmd_stb <= (i == 0);
            seq = seq >> 8;
        end
        @(posedge mclk);
        cmd_stb <= 1'b0;
        cmd_ad  <= 8'h00;
        repeat (3) @(posedge mclk);     // cmd_we 2 cycles after D3, then reg update
    endtask

    // one-cycle sof or eol, outputs expected exactly one cycle later
    task automatic strobe_and_check(input logic [1:0] chn, input bit is_eol,
                                    input int exp_sof, input int exp_late);
        @(posedge mclk);
        if (is_eol) begin
            eol_in[chn] <= 1'b1;
        end else begin
            sof_in[chn] <= 1'b1;
        end
        @(negedge mclk);
        if (sof_out_mclk[chn] || sof_late_mclk[chn]) begin
            report_failure("sync output rose in the same cycle as its input strobe");
        end
        @(posedge mclk);
        sof_in[chn] <= 1'b0;
        eol_in[chn] <= 1'b0;
        @(negedge mclk);
        if (int'(sof_out_mclk[chn]) != exp_sof) begin
            report_mismatch("sof_out_mclk", exp_sof, int'(sof_out_mclk[chn]));
        end
        if (int'(sof_late_mclk[chn]) != exp_late) begin
            report_mismatch("sof_late_mclk", exp_late, int'(sof_late_mclk[chn]));
        end
    endtask

    // waits for status_rq, gives one start pulse and collects four bytes
    task automatic fetch_and_check_packet(input logic [1:0] chn);
        logic [31:0] pkt;
        logic [31:0] exp_pkt;
        int          waited;
        pkt     = '0;
        exp_pkt = {6'b0, exp_sync[chn] == SYNC_WAIT_LATE, 1'b1,  // byte 3, always enabled
                   16'(frames[chn]),
                   8'(`SENSI2C_STATUS_REG_BASE + int'(chn) * `SENSI2C_STATUS_REG_INC)};
        waited  = 0;
        @(negedge mclk);
        while (!status_rq && waited < 64) begin
            @(negedge mclk);
            waited++;
        end
        if (!status_rq) begin
            report_failure("status_rq never rose for a pending status request");
        end else begin
            @(posedge mclk);
            status_start <= 1'b1;
            for (int b = 0; b < `STATUS_BYTES; b++) begin
                @(negedge mclk);
                pkt = {status_ad, pkt[31:8]};
                if (status_rq != (b == 0)) begin
                    report_failure("status_rq not low during the packet bytes");
                end
                @(posedge mclk);
                status_start <= 1'b0;
            end
            for (int b = 0; b < `STATUS_BYTES; b++) begin
                if (pkt[7:0] != exp_pkt[7:0]) begin
                    report_mismatch($sformatf("status byte %0d", b),
                                    int'(exp_pkt[7:0]), int'(pkt[7:0]));
                end
                pkt     = pkt >> 8;
                exp_pkt = exp_pkt >> 8;
            end
        end
    endtask

    task automatic test_reset_state();
        cur_test = "reset_state";
        @(negedge mclk);
        if ({status_rq, sof_out_mclk, sof_late_mclk} !== 9'h000) begin
            report_mismatch("status_rq, sof_out_mclk, sof_late_mclk", 0,
                            int'({status_rq, sof_out_mclk, sof_late_mclk}));
        end
        end_test();
    endtask

    task automatic test_enable_pass();
        cur_test = "enable_pass";
        write_reg(2'd0, `SENS_SYNC_LATE_RADDR, 32'd0);   // late sof with the frame
        repeat (3) strobe_and_check(2'd0, 1'b0, 0, 0);   // still disabled
        write_reg(2'd0, `SENSOR_CTRL_RADDR, 32'd1 << `SENSOR_CHN_EN_BIT);
        repeat (4) begin
            strobe_and_check(2'd0, 1'b0, 1, 1);          // mult 0, every frame
            frames[0]++;
        end
        end_test();
    endtask

    task automatic test_decimation();
        int n_sof;
        int hit;
        cur_test = "decimation";
        n_sof = 6 + int'($urandom % 10);
        write_reg(2'd1, `SENS_SYNC_LATE_RADDR, 32'd0);
        write_reg(2'd1, `SENS_SYNC_MULT_RADDR, 32'd2);   // one frame out of three
        write_reg(2'd1, `SENSOR_CTRL_RADDR, 32'd1);
        for (int i = 0; i < n_sof; i++) begin
            hit = (i % 3 == 0) ? 1 : 0;                  // 1st, 4th, 7th ...
            strobe_and_check(2'd1, 1'b0, hit, hit);
            frames[1] += hit;
        end
        end_test();
    endtask

    task automatic test_late_sof();
        cur_test = "late_sof";
        write_reg(2'd3, `SENS_SYNC_LATE_RADDR, 32'd3);
        write_reg(2'd3, `SENSOR_CTRL_RADDR, 32'd1);
        strobe_and_check(2'd3, 1'b0, 1, 0);              // late sof pending
        for (int i = 1; i <= 4; i++) begin
            strobe_and_check(2'd3, 1'b1, 0, (i == 3) ? 1 : 0);
        end
        write_reg(2'd3, `SENS_SYNC_LATE_RADDR, 32'd0);
        strobe_and_check(2'd3, 1'b0, 1, 1);              // late 0, same cycle
        frames[3] += 2;
        end_test();
    endtask

    task automatic test_status_packet();
        int n_frames;
        cur_test = "status_packet";
        n_frames = 256 + int'($urandom % 200);           // reaches the high byte
        write_reg(2'd2, `SENS_SYNC_LATE_RADDR, 32'd0);
        write_reg(2'd2, `SENSOR_CTRL_RADDR, 32'd1);
        repeat (n_frames) begin
            strobe_and_check(2'd2, 1'b0, 1, 1);
            frames[2]++;
        end
        write_reg(2'd2, `SENS_STATUS_CTRL_RADDR, 32'd0);
        fetch_and_check_packet(2'd2);
        end_test();
    endtask

    task automatic test_round_robin();
        cur_test = "round_robin";
        write_reg(2'd0, `SENS_SYNC_LATE_RADDR, 32'd5);
        strobe_and_check(2'd0, 1'b0, 1, 0);              // ch0 left waiting for late sof
        frames[0]++;
        exp_sync[0] = SYNC_WAIT_LATE;
        write_reg(2'd2, `SENS_STATUS_CTRL_RADDR, 32'd0); // router busy offering 2
        write_reg(2'd0, `SENS_STATUS_CTRL_RADDR, 32'd0);
        write_reg(2'd1, `SENS_STATUS_CTRL_RADDR, 32'd0);
        write_reg(2'd3, `SENS_STATUS_CTRL_RADDR, 32'd0);
        fetch_and_check_packet(2'd2);
        fetch_and_check_packet(2'd3);                    // search restarts after 2
        fetch_and_check_packet(2'd0);
        fetch_and_check_packet(2'd1);
        end_test();
    endtask

    initial begin
        void'($urandom(40));
        reset        = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        sof_in       = 4'h0;
        eol_in       = 4'h0;
        status_start = 1'b0;
        repeat (8) @(posedge mclk);
        reset <= 1'b0;
        test_reset_state();
        test_enable_pass();
        test_decimation();
        test_late_sof();
        test_status_packet();
        test_round_robin();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/sensors_pkg.sv
src/cmd_deser.sv
src/sens_sync.sv
src/sensor_channel.sv
src/status_router.sv
src/sensors_top.sv
tb/tb_sensors.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sensor subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_sensors \
    -f filelist.f -o tb_sensors > build.log 2>&1 \
    && ./obj_dir/tb_sensors > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
